// File: rtl/kvs_stream_pkg.sv
package kvs_stream_pkg;

  // ------------------------------
  // stream widths and types
  // ------------------------------
  localparam int WORD_W = 64;
  localparam int META_W = 64;

  typedef logic [WORD_W-1:0] word_t;
  // session id sits in the low 16 bits
  typedef logic [META_W-1:0] meta_t;
  typedef logic [15:0]       session_t;
  typedef logic [15:0]       len_t;
  // length in the upper half, session id in the lower half
  typedef logic [31:0]       tx_meta_t;

  // every beat is counted as a full word
  localparam len_t BYTES_PER_WORD = 16'd8;

  // ------------------------------
  // fifo depths as address bits
  // ------------------------------
  // 256 entries
  localparam int RX_FIFO_AW   = 8;
  // 64 entries
  localparam int TX_FIFO_AW   = 6;
  // 16 entries
  localparam int META_FIFO_AW = 4;

endpackage

// File: rtl/kvs_conn_pkg.sv
package kvs_conn_pkg;

  // ------------------------------
  // connection side definitions
  // ------------------------------

  // tcp port number
  typedef logic [15:0] port_t;

  // range opened once after reset
  // ports 2880 up to 2887
  localparam port_t LISTEN_PORT_FIRST = 16'd2880;
  localparam int    LISTEN_PORT_COUNT = 8;

endpackage

// File: rtl/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
  parameter int WIDTH     = 64,
  parameter int ADDR_BITS = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  // write side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  // read side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // pointers carry one extra wrap bit
  logic [ADDR_BITS:0] wr_ptr;
  logic [ADDR_BITS:0] rd_ptr;
  logic [ADDR_BITS:0] count;
  logic [WIDTH-1:0]   mem [2**ADDR_BITS];
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  // ------------------------------
  // status
  // ------------------------------
  assign count = wr_ptr - rd_ptr;
  assign empty = (wr_ptr == rd_ptr);
  // same slot, different lap
  assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                 (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // head entry falls through to the output
  assign out_data = mem[rd_ptr[ADDR_BITS-1:0]];

  // ------------------------------
  // storage and pointers
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr[ADDR_BITS-1:0]] <= in_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // a stalled head word must not move under the reader
  a_hold_data: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> $stable(out_data)
  ) else $error("stream_fifo: head word changed while stalled");

  // pointer distance stays within the buffer
  a_count_bound: assert property (
    @(posedge aclk) disable iff (!aresetn)
    count <= 2**ADDR_BITS
  ) else $error("stream_fifo: entry count %0d above depth", count);

endmodule

// File: rtl/listen_port_opener.sv
`timescale 1ns/100ps

module listen_port_opener
  import kvs_conn_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  listen_ready,
  output logic  listen_valid,
  output port_t listen_port
);

  port_t next_port;
  logic  range_left;
  logic  fire;

  // ports still left to open
  assign range_left = (next_port < port_t'(LISTEN_PORT_FIRST + LISTEN_PORT_COUNT));

  // qualify on the registered strobe so two never touch
  assign fire = listen_ready && !listen_valid && range_left;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      listen_valid <= 1'b0;
      next_port    <= LISTEN_PORT_FIRST;
    end else begin
      listen_valid <= fire;
      if (fire) begin
        next_port <= next_port + 1'b1;
      end
    end
  end

  // port of the strobe being issued
  always_ff @(posedge aclk) begin
    if (fire) begin
      listen_port <= next_port;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // the network sees at most one strobe per two cycles
  a_no_adjacent: assert property (
    @(posedge aclk) disable iff (!aresetn)
    listen_valid |=> !listen_valid
  ) else $error("listen_port_opener: adjacent listen strobes");

endmodule

// File: rtl/tx_meta_framer.sv
`timescale 1ns/100ps

module tx_meta_framer
  import kvs_stream_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,
  // response beats from the store
  input  logic     resp_valid,
  output logic     resp_ready,
  input  meta_t    resp_meta,
  input  logic     resp_last,
  // transmit data fifo side
  input  logic     data_ready,
  output logic     beat_push,
  // metadata fifo side
  output logic     meta_valid,
  input  logic     meta_ready,
  output tx_meta_t meta_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BODY,
    ST_PEND
  } framer_state_t;

  framer_state_t state;
  len_t          len_cnt;
  session_t      session;
  len_t          len_next;
  session_t      session_next;
  logic          first_beat;
  logic          meta_stall;

  // entry waiting and nobody taking it
  assign meta_stall = (state == ST_PEND) && !meta_ready;
  assign resp_ready = data_ready && !meta_stall;
  assign beat_push  = resp_valid && resp_ready;
  assign meta_valid = (state == ST_PEND);

  // outside a packet the beat opens a new one
  assign first_beat   = (state != ST_BODY);
  assign len_next     = first_beat ? BYTES_PER_WORD : len_cnt + BYTES_PER_WORD;
  assign session_next = first_beat ? resp_meta[15:0] : session;

  // ------------------------------
  // packet state
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= ST_IDLE;
      len_cnt <= '0;
    end else begin
      if (beat_push) begin
        len_cnt <= len_next;
      end
      unique case (state)
        ST_IDLE: begin
          if (beat_push) begin
            state <= resp_last ? ST_PEND : ST_BODY;
          end
        end
        ST_BODY: begin
          if (beat_push && resp_last) begin
            state <= ST_PEND;
          end
        end
        ST_PEND: begin
          // entry leaves now, next packet may already start
          if (beat_push) begin
            state <= resp_last ? ST_PEND : ST_BODY;
          end else if (meta_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // session and metadata word, loaded by accepted beats
  always_ff @(posedge aclk) begin
    if (beat_push) begin
      session <= session_next;
      if (resp_last) begin
        meta_word <= {len_next, session_next};
      end
    end
  end

  a_meta_len: assert property (
    @(posedge aclk) disable iff (!aresetn)
    meta_valid |-> (meta_word[31:16] != '0) && (meta_word[31:16] % BYTES_PER_WORD == '0)
  ) else $error("tx_meta_framer: bad length %0d in metadata", meta_word[31:16]);

endmodule

// File: rtl/kvs_net_shell.sv
`timescale 1ns/100ps

module kvs_net_shell
  import kvs_stream_pkg::*;
  import kvs_conn_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,

  // listen port requests toward the network
  output logic     listen_valid,
  input  logic     listen_ready,
  output port_t    listen_port,

  // received stream from the network
  input  logic     rx_valid,
  output logic     rx_ready,
  input  word_t    rx_data,
  input  logic     rx_last,

  // request stream toward the store
  output logic     req_valid,
  input  logic     req_ready,
  output word_t    req_data,
  output logic     req_last,

  // response stream from the store
  input  logic     resp_valid,
  output logic     resp_ready,
  input  word_t    resp_data,
  input  meta_t    resp_meta,
  input  logic     resp_last,

  // transmit data toward the network
  output logic     tx_data_valid,
  input  logic     tx_data_ready,
  output word_t    tx_data,
  output logic     tx_last,

  // transmit metadata toward the network
  output logic     tx_meta_valid,
  input  logic     tx_meta_ready,
  output tx_meta_t tx_meta
);

  // last flag travels in the top bit
  logic [WORD_W:0] rx_in_word;
  logic [WORD_W:0] rx_out_word;
  logic [WORD_W:0] tx_in_word;
  logic [WORD_W:0] tx_out_word;

  logic            beat_push;
  logic            data_ready;
  logic            meta_valid;
  logic            meta_ready;
  tx_meta_t        meta_word;

  // ------------------------------
  // listen ports
  // ------------------------------
  listen_port_opener i_listen (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .listen_ready (listen_ready),
    .listen_valid (listen_valid),
    .listen_port  (listen_port)
  );

  // ------------------------------
  // receive path
  // ------------------------------
  assign rx_in_word = {rx_last, rx_data};

  stream_fifo #(
    .WIDTH     (WORD_W + 1),
    .ADDR_BITS (RX_FIFO_AW)
  ) i_rx_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (rx_valid),
    .in_ready  (rx_ready),
    .in_data   (rx_in_word),
    .out_valid (req_valid),
    .out_ready (req_ready),
    .out_data  (rx_out_word)
  );

  assign req_data = rx_out_word[WORD_W-1:0];
  assign req_last = rx_out_word[WORD_W];

  // ------------------------------
  // transmit path
  // ------------------------------
  // data fifo is fed by accepted response beats
  assign tx_in_word = {resp_last, resp_data};

  stream_fifo #(
    .WIDTH     (WORD_W + 1),
    .ADDR_BITS (TX_FIFO_AW)
  ) i_tx_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (beat_push),
    .in_ready  (data_ready),
    .in_data   (tx_in_word),
    .out_valid (tx_data_valid),
    .out_ready (tx_data_ready),
    .out_data  (tx_out_word)
  );

  assign tx_data = tx_out_word[WORD_W-1:0];
  assign tx_last = tx_out_word[WORD_W];

  // one metadata entry per response packet
  tx_meta_framer i_framer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_meta  (resp_meta),
    .resp_last  (resp_last),
    .data_ready (data_ready),
    .beat_push  (beat_push),
    .meta_valid (meta_valid),
    .meta_ready (meta_ready),
    .meta_word  (meta_word)
  );

  stream_fifo #(
    .WIDTH     ($bits(tx_meta_t)),
    .ADDR_BITS (META_FIFO_AW)
  ) i_meta_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (meta_valid),
    .in_ready  (meta_ready),
    .in_data   (meta_word),
    .out_valid (tx_meta_valid),
    .out_ready (tx_meta_ready),
    .out_data  (tx_meta)
  );

endmodule

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ------------------------------
// receive words, one per entry
// ------------------------------
localparam int RX_WORDS = 40;

localparam word_t rx_words [RX_WORDS] = '{
  64'h0001_0203_0405_0607, 64'h1011_1213_1415_1617, 64'h2021_2223_2425_2627,
  64'h3031_3233_3435_3637, 64'hdead_beef_0000_0004, 64'hffff_ffff_ffff_ffff,
  64'h0000_0000_0000_0000, 64'h8000_0000_0000_0001, 64'h5a5a_5a5a_a5a5_a5a5,
  64'hc0ff_ee00_1234_5678, 64'h0f0f_0f0f_f0f0_f0f0, 64'h1357_9bdf_0246_8ace,
  64'h7e57_0000_0000_000c, 64'h4b45_5900_0000_000d, 64'h5641_4c00_0000_000e,
  64'hfedc_ba98_7654_3210, 64'h0101_0101_0101_0101, 64'h2222_4444_8888_1111,
  64'h9abc_def0_1234_5678, 64'h0000_ffff_0000_ffff, 64'h3c3c_c3c3_3c3c_c3c3,
  64'h6b76_7300_0000_0015, 64'h0123_0000_4567_0000, 64'h89ab_cdef_89ab_cdef,
  64'h7777_0000_7777_0000, 64'h0000_0000_0000_0019, 64'habcd_ef01_2345_6789,
  64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h9999_aaaa_bbbb_cccc,
  64'hdddd_eeee_ffff_0000, 64'h0042_0042_0042_0042, 64'h8421_8421_8421_8421,
  64'h0000_0001_0000_0002, 64'hcafe_f00d_0000_0022, 64'h600d_0000_0000_0023,
  64'h0bad_cafe_0000_0024, 64'h1f2e_3d4c_5b6a_7988, 64'h00ff_00ff_00ff_00ff,
  64'h4e45_5400_0000_0027
};

// last flag per receive word
localparam bit rx_last_tab [RX_WORDS] = '{
  0, 0, 0, 1, 0, 0, 0, 1, 1, 0,
  0, 0, 0, 0, 1, 0, 0, 0, 0, 1,
  0, 0, 1, 0, 0, 0, 0, 1, 0, 0,
  0, 1, 0, 0, 0, 1, 0, 0, 0, 1
};

// ------------------------------
// response packets
// ------------------------------
localparam int RESP_PKTS  = 10;
localparam int RESP_BEATS = 31;

localparam int resp_beats [RESP_PKTS] = '{1, 3, 6, 2, 4, 1, 5, 2, 6, 1};

// metadata on the first beat, session id in the low 16 bits
localparam meta_t resp_first_meta [RESP_PKTS] = '{
  64'h6d65_7461_0000_1a01, 64'h6d65_7461_0000_2b02, 64'h6d65_7461_0000_3c03,
  64'h6d65_7461_0000_4d04, 64'h6d65_7461_0000_5e05, 64'h6d65_7461_0000_6f06,
  64'h6d65_7461_0000_7a07, 64'h6d65_7461_0000_8b08, 64'h6d65_7461_0000_9c09,
  64'h6d65_7461_0000_ad0a
};

// all beats of all packets back to back
localparam word_t resp_words [RESP_BEATS] = '{
  64'h7265_7370_0000_0000, 64'h7265_7370_0000_0100, 64'h7265_7370_0000_0101,
  64'h7265_7370_0000_0102, 64'h7265_7370_0000_0200, 64'h7265_7370_0000_0201,
  64'h7265_7370_0000_0202, 64'h7265_7370_0000_0203, 64'h7265_7370_0000_0204,
  64'h7265_7370_0000_0205, 64'h7265_7370_0000_0300, 64'h7265_7370_0000_0301,
  64'h7265_7370_0000_0400, 64'h7265_7370_0000_0401, 64'h7265_7370_0000_0402,
  64'h7265_7370_0000_0403, 64'h7265_7370_0000_0500, 64'h7265_7370_0000_0600,
  64'h7265_7370_0000_0601, 64'h7265_7370_0000_0602, 64'h7265_7370_0000_0603,
  64'h7265_7370_0000_0604, 64'h7265_7370_0000_0700, 64'h7265_7370_0000_0701,
  64'h7265_7370_0000_0800, 64'h7265_7370_0000_0801, 64'h7265_7370_0000_0802,
  64'h7265_7370_0000_0803, 64'h7265_7370_0000_0804, 64'h7265_7370_0000_0805,
  64'h7265_7370_0000_0900
};

// expected tx_meta per packet, byte length over session id
localparam tx_meta_t exp_meta [RESP_PKTS] = '{
  32'h0008_1a01, 32'h0018_2b02, 32'h0030_3c03, 32'h0010_4d04, 32'h0020_5e05,
  32'h0008_6f06, 32'h0028_7a07, 32'h0010_8b08, 32'h0030_9c09, 32'h0008_ad0a
};

`endif

// File: tb/tb_kvs_net_shell.sv
`timescale 1ns/100ps

module tb_kvs_net_shell
  import kvs_stream_pkg::*;
  import kvs_conn_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int RX_ROUNDS      = 2;
  localparam int RESP_ROUNDS    = 4;
  localparam int HOLD_CYCLES    = 300;
  localparam int TIMEOUT_CYCLES = 20 * (RX_WORDS + RESP_PKTS) + 500;

  logic aclk, aresetn;
  logic listen_valid, listen_ready;
  port_t listen_port;
  logic rx_valid, rx_ready, rx_last;
  word_t rx_data;
  logic req_valid, req_ready, req_last;
  word_t req_data;
  logic resp_valid, resp_ready, resp_last;
  word_t resp_data;
  meta_t resp_meta;
  logic tx_data_valid, tx_data_ready, tx_last;
  word_t tx_data;
  logic tx_meta_valid, tx_meta_ready;
  tx_meta_t tx_meta;

  int seed;
  int errors, checks;
  int req_seen, tx_seen, meta_seen, ports_seen;
  logic prev_listen, hold_tx, stall_seen;

  kvs_net_shell i_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // true when beat k of the flat table closes its packet
  function automatic logic closes_packet(int k);
    int p;
    int acc;
    acc = 0;
    for (p = 0; p < RESP_PKTS; p++) begin
      acc += resp_beats[p];
      if (k == acc - 1) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic compare_value(input string what, input int idx,
                               input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL @%0t: %s %0d is %h, expected %h", $time, what, idx, got, exp);
    end
  endtask

  task automatic flag_extra(input string what);
    errors++;
    $display("FAIL @%0t: unexpected extra %s", $time, what);
  endtask

  task automatic send_rx_round();
    int i;
    for (i = 0; i < RX_WORDS; i++) begin
      rx_valid = 1'b1;
      rx_data  = rx_words[i];
      rx_last  = rx_last_tab[i];
      @(negedge aclk);
      while (!rx_ready) @(negedge aclk);
      @(posedge aclk);
      #2;
    end
    rx_valid = 1'b0;
  endtask

  task automatic send_resp_round();
    int p;
    int b;
    int k;
    k = 0;
    for (p = 0; p < RESP_PKTS; p++) begin
      for (b = 0; b < resp_beats[p]; b++) begin
        resp_valid = 1'b1;
        resp_data  = resp_words[k];
        resp_last  = (b == resp_beats[p] - 1);
        // later beats carry junk metadata that must be ignored
        resp_meta  = (b == 0) ? resp_first_meta[p] : {48'hbad0_bad0_bad0, 16'(k)};
        @(negedge aclk);
        while (!resp_ready) @(negedge aclk);
        @(posedge aclk);
        #2;
        k++;
      end
    end
    resp_valid = 1'b0;
  endtask

  // ------------------------------
  // output ready toggling
  // ------------------------------
  always @(posedge aclk) begin
    #2;
    listen_ready  = random_bit();
    req_ready     = random_bit();
    tx_data_ready = hold_tx ? 1'b0 : random_bit();
    tx_meta_ready = hold_tx ? 1'b0 : random_bit();
  end

  // ------------------------------
  // monitors, mid cycle
  // ------------------------------
  always @(negedge aclk) begin
    if (aresetn) begin
      if (listen_valid) begin
        if (prev_listen) begin
          errors++;
          $display("FAIL @%0t: listen strobes on adjacent cycles", $time);
        end
        if (ports_seen >= LISTEN_PORT_COUNT) flag_extra("listen strobe");
        else compare_value("listen port", ports_seen, 64'(listen_port),
                           64'(LISTEN_PORT_FIRST) + 64'(ports_seen));
        ports_seen++;
      end
      prev_listen = listen_valid;
      if (req_valid && req_ready) begin
        if (req_seen >= RX_WORDS * RX_ROUNDS) begin
          flag_extra("req word");
        end else begin
          compare_value("req data", req_seen, req_data, rx_words[req_seen % RX_WORDS]);
          compare_value("req last", req_seen, 64'(req_last),
                        64'(rx_last_tab[req_seen % RX_WORDS]));
        end
        req_seen++;
      end
      if (tx_data_valid && tx_data_ready) begin
        if (tx_seen >= RESP_BEATS * RESP_ROUNDS) begin
          flag_extra("tx beat");
        end else begin
          compare_value("tx data", tx_seen, tx_data, resp_words[tx_seen % RESP_BEATS]);
          compare_value("tx last", tx_seen, 64'(tx_last),
                        64'(closes_packet(tx_seen % RESP_BEATS)));
        end
        tx_seen++;
      end
      if (tx_meta_valid && tx_meta_ready) begin
        if (meta_seen >= RESP_PKTS * RESP_ROUNDS) flag_extra("tx meta word");
        else compare_value("tx meta", meta_seen, 64'(tx_meta),
                           64'(exp_meta[meta_seen % RESP_PKTS]));
        meta_seen++;
      end
      if (hold_tx && !resp_ready) stall_seen = 1'b1;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout after %0d cycles, streams still incomplete:", cycles);
    if (ports_seen < LISTEN_PORT_COUNT) $display("  listen: %0d strobes", ports_seen);
    if (req_seen < RX_WORDS * RX_ROUNDS) $display("  req: %0d words", req_seen);
    if (tx_seen < RESP_BEATS * RESP_ROUNDS) $display("  tx data: %0d beats", tx_seen);
    if (meta_seen < RESP_PKTS * RESP_ROUNDS) $display("  tx meta: %0d words", meta_seen);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed = 32'hc04;
    {errors, checks, req_seen, tx_seen, meta_seen, ports_seen} = '0;
    {prev_listen, hold_tx, stall_seen} = '0;
    aresetn = 1'b0;
    {listen_ready, req_ready, tx_data_ready, tx_meta_ready} = '0;
    {rx_valid, rx_last, resp_valid, resp_last} = '0;
    rx_data   = '0;
    resp_data = '0;
    resp_meta = '0;
    repeat (5) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    @(negedge aclk);
    if (listen_valid || req_valid || tx_data_valid || tx_meta_valid ||
        !rx_ready || !resp_ready) begin
      errors++;
      $display("FAIL @%0t: output state after reset is wrong", $time);
    end
    @(posedge aclk);
    #2;
    fork
      send_rx_round();
      send_resp_round();
    join
    // back-pressure phase with the transmit side blocked
    fork
      begin
        @(posedge aclk);
        hold_tx = 1'b1;
        repeat (HOLD_CYCLES) @(posedge aclk);
        hold_tx = 1'b0;
      end
      send_rx_round();
      repeat (RESP_ROUNDS - 1) send_resp_round();
    join
    wait (req_seen == RX_WORDS * RX_ROUNDS && tx_seen == RESP_BEATS * RESP_ROUNDS &&
          meta_seen == RESP_PKTS * RESP_ROUNDS && ports_seen == LISTEN_PORT_COUNT);
    repeat (20) @(posedge aclk);
    if (!stall_seen) begin
      errors++;
      $display("resp_ready never dropped while the transmit side was held");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+tb
rtl/kvs_stream_pkg.sv
rtl/kvs_conn_pkg.sv
rtl/stream_fifo.sv
rtl/listen_port_opener.sv
rtl/tx_meta_framer.sv
rtl/kvs_net_shell.sv
tb/tb_kvs_net_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# build the testbench with the shell as DUT
verilator --binary --timing -Wno-fatal \
  --top-module tb_kvs_net_shell \
  -f sim.f

# run and keep the output for the verdict
sim_out=$(./obj_dir/Vtb_kvs_net_shell)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
else
  exit 1
fi
